//--- sim.f
+incdir+include
hdl/rvExecPkg.sv
hdl/stageLink.sv
hdl/instrIntake.sv
hdl/operandStage.sv
hdl/executeStage.sv
hdl/resultSender.sv
hdl/rvExecTop.sv
dv/rvExecAssertions.sv
dv/rvExecTb.sv

//--- dv/rvExecTb.sv
//********************
// every register is written before it is read
// responder delay is random unless a stall length is set
//********************
`timescale 1ns/1ps

module rvExecTb;
	localparam int waitLimit = 600;
	localparam logic [1:0] RESP_IDLE = 2'd0;
	localparam logic [1:0] RESP_DELAY = 2'd1;
	localparam logic [1:0] RESP_ACKED = 2'd2;

	logic clk;
	logic reset;
	logic inRequest;
	logic [31:0] inInstr;
	logic [31:0] inPc;
	logic inAck;
	logic outRequest;
	logic outAck;
	logic [4:0] outRd;
	logic [31:0] outResult;
	logic outIllegal;

	// reference register file
	logic [31:0] modelRegs [32];
	// expected returns as {illegal, rd, result}, oldest first
	logic [37:0] expected [$];
	logic [31:0] pcNext;
	logic [1:0] respState;
	int delayLeft;
	int holdCount;
	int releaseLeft;
	int stallCycles;

	rvExecTop #(.regCount(32)) DUT (.*);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	task automatic abortRun(input string reason);
		$display("%s", reason);
		$display("Something failed");
		$fatal(1, "run stopped");
	endtask

	function automatic logic [31:0] rWord(input logic [6:0] f7, input logic [4:0] rs2,
		input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd);
		return {f7, rs2, rs1, f3, rd, 7'b0110011};
	endfunction

	function automatic logic [31:0] iWord(input logic [11:0] imm, input logic [4:0] rs1,
		input logic [2:0] f3, input logic [4:0] rd);
		return {imm, rs1, f3, rd, 7'b0010011};
	endfunction

	function automatic logic [31:0] uWord(input logic [19:0] imm, input logic [4:0] rd,
		input logic [6:0] opcode);
		return {imm, rd, opcode};
	endfunction

	// ISA arithmetic, alt is instruction bit 30
	function automatic logic [31:0] aluReference(input logic [2:0] f3, input logic alt,
		input logic [31:0] a, input logic [31:0] b);
		logic [31:0] y;
		case (f3)
			3'd0: y = alt ? a - b : a + b;
			3'd1: y = a << b[4:0];
			3'd2: y = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
			3'd3: y = (a < b) ? 32'd1 : 32'd0;
			3'd4: y = a ^ b;
			3'd5: begin
				if (alt) begin
					y = $signed(a) >>> b[4:0];
				end else begin
					y = a >> b[4:0];
				end
			end
			3'd6: y = a | b;
			default: y = a & b;
		endcase
		return y;
	endfunction

	// update the model and queue what the slice must return
	function automatic void applyToModel(input logic [31:0] instr, input logic [31:0] pc);
		logic [4:0] rd;
		logic [2:0] f3;
		logic [31:0] a;
		logic [31:0] immI;
		logic [31:0] immU;
		logic [31:0] res;
		logic illegal;
		rd = instr[11:7];
		f3 = instr[14:12];
		a = modelRegs[instr[19:15]];
		immI = {{20{instr[31]}}, instr[31:20]};
		immU = {instr[31:12], 12'b0};
		illegal = 1'b0;
		case (instr[6:0])
			7'b0110011: res = aluReference(f3, instr[30], a, modelRegs[instr[24:20]]);
			// no SUBI, bit 30 only marks SRAI
			7'b0010011: res = aluReference(f3, instr[30] && (f3 == 3'd5), a, immI);
			7'b0110111: res = immU;
			7'b0010111: res = pc + immU;
			default: begin
				illegal = 1'b1;
				res = '0;
			end
		endcase
		if (!illegal && (rd != 5'd0)) begin
			modelRegs[rd] = res;
		end
		expected.push_back({illegal, rd, res});
	endfunction

	// four-phase send, called on a rising edge
	task automatic sendInstr(input logic [31:0] instr, input logic [31:0] pc);
		int count;
		applyToModel(instr, pc);
		inInstr <= instr;
		inPc <= pc;
		inRequest <= 1'b1;
		count = 0;
		@(posedge clk);
		// ack stays low while the slice is stalled
		while (inAck !== 1'b1) begin
			count++;
			if (count > waitLimit) begin
				abortRun("inAck never rose after inRequest was raised");
			end
			@(posedge clk);
		end
		inRequest <= 1'b0;
		count = 0;
		@(posedge clk);
		while (inAck !== 1'b0) begin
			count++;
			if (count > waitLimit) begin
				abortRun("inAck stayed high after inRequest was dropped");
			end
			@(posedge clk);
		end
	endtask

	task automatic sendRandomAlu();
		logic [4:0] rd;
		logic [4:0] rs1;
		logic [4:0] rs2;
		logic [2:0] f3;
		logic alt;
		logic [11:0] imm;
		rd = 5'($urandom);
		rs1 = 5'($urandom);
		rs2 = 5'($urandom);
		f3 = 3'($urandom);
		// bit 30 only for SUB, SRA and SRAI
		alt = ((f3 == 3'd0) || (f3 == 3'd5)) && ($urandom_range(0, 1) == 1);
		if ($urandom_range(0, 1) == 1) begin
			sendInstr(rWord({1'b0, alt, 5'b0}, rs2, rs1, f3, rd), pcNext);
		end else begin
			// shifts take a shamt, ADDI may carry bit 10 and stays an add
			if ((f3 == 3'd1) || (f3 == 3'd5)) begin
				imm = {1'b0, alt, 5'b0, rs2};
			end else begin
				imm = 12'($urandom);
			end
			sendInstr(iWord(imm, rs1, f3, rd), pcNext);
		end
		pcNext += 4;
	endtask

	task automatic checkResult();
		logic [37:0] exp;
		if (expected.size() == 0) begin
			abortRun("a result came out that no instruction asked for");
		end
		exp = expected.pop_front();
		assert (outRd == exp[36:32]) else begin
			abortRun($sformatf("ERROR at %0t ns: outRd is %0d, expected %0d",
				$time, outRd, exp[36:32]));
		end
		assert (outResult == exp[31:0]) else begin
			abortRun($sformatf("ERROR at %0t ns: outResult is %h, expected %h",
				$time, outResult, exp[31:0]));
		end
		assert (outIllegal == exp[37]) else begin
			abortRun($sformatf("ERROR at %0t ns: outIllegal is %b, expected %b",
				$time, outIllegal, exp[37]));
		end
	endtask

	// result port responder, one op per req/ack cycle
	initial begin
		outAck = 1'b0;
		respState = RESP_IDLE;
		delayLeft = 0;
		holdCount = 0;
		releaseLeft = 0;
		forever begin
			@(posedge clk);
			if (reset) begin
				outAck <= 1'b0;
				respState <= RESP_IDLE;
			end else begin
				case (respState)
					RESP_IDLE: begin
						if (outRequest) begin
							checkResult();
							delayLeft <= (stallCycles > 0) ? stallCycles : $urandom_range(0, 3);
							respState <= RESP_DELAY;
						end
					end
					RESP_DELAY: begin
						if (delayLeft == 0) begin
							outAck <= 1'b1;
							holdCount <= 0;
							// a stall also keeps ack high well after req drops
							releaseLeft <= stallCycles;
							respState <= RESP_ACKED;
						end else begin
							delayLeft <= delayLeft - 1;
						end
					end
					default: begin
						if (outRequest) begin
							if (holdCount > waitLimit) begin
								abortRun("outRequest stayed high after outAck was raised");
							end else begin
								holdCount <= holdCount + 1;
							end
						end else if (releaseLeft > 0) begin
							releaseLeft <= releaseLeft - 1;
						end else begin
							outAck <= 1'b0;
							respState <= RESP_IDLE;
						end
					end
				endcase
			end
		end
	end

	// bound protocol checks stop the run at once
	always @(posedge clk) begin
		if (DUT.protoChecks.failCount != 0) begin
			abortRun("a protocol assertion on the external ports failed");
		end
	end

	initial begin
		int i;
		int count;
		logic [4:0] prev;
		logic [4:0] rd;
		void'($urandom(97));
		reset = 1'b1;
		inRequest = 1'b0;
		inInstr = '0;
		inPc = '0;
		stallCycles = 0;
		pcNext = 32'h0000_1000;
		for (i = 0; i < 32; i++) begin
			modelRegs[i] = '0;
		end
		repeat (4) @(posedge clk);
		reset <= 1'b0;
		@(posedge clk);
		// known value in every register
		for (i = 1; i < 32; i++) begin
			sendInstr(iWord(12'($urandom), 5'd0, 3'd0, 5'(i)), pcNext);
			pcNext += 4;
		end
		for (i = 0; i < 60; i++) begin
			sendRandomAlu();
		end
		// SUB, SRA and SRAI on a negative value
		sendInstr(uWord(20'h80000, 5'd3, 7'b0110111), pcNext);
		sendInstr(rWord(7'h20, 5'd4, 5'd3, 3'd0, 5'd5), pcNext);
		sendInstr(rWord(7'h20, 5'd6, 5'd3, 3'd5, 5'd7), pcNext);
		sendInstr(iWord(12'h407, 5'd3, 3'd5, 5'd8), pcNext);
		// LUI and AUIPC at random word addresses
		for (i = 0; i < 8; i++) begin
			sendInstr(uWord(20'($urandom), 5'($urandom_range(1, 31)),
				(i % 2 == 1) ? 7'b0010111 : 7'b0110111), 32'($urandom) & ~32'd3);
		end
		// slow responder keeps ops queued so each reads the one in execute
		stallCycles <= 6;
		prev = 5'd1;
		for (i = 0; i < 12; i++) begin
			rd = 5'($urandom_range(1, 31));
			if (i % 2 == 0) begin
				sendInstr(rWord(7'h00, prev, prev, 3'd0, rd), pcNext);
			end else begin
				sendInstr(iWord(12'($urandom), prev, 3'd4, rd), pcNext);
			end
			prev = rd;
		end
		// writes to x0 are dropped
		sendInstr(iWord(12'h123, 5'd0, 3'd0, 5'd0), pcNext);
		sendInstr(rWord(7'h00, 5'd0, 5'd0, 3'd0, 5'd9), pcNext);
		sendInstr(iWord(12'h7ff, 5'd0, 3'd6, 5'd0), pcNext);
		sendInstr(rWord(7'h00, 5'd0, 5'd9, 3'd6, 5'd10), pcNext);
		// a load and a jump are illegal here and leave rd alone
		sendInstr({12'h004, 5'd2, 3'd2, 5'd11, 7'b0000011}, pcNext);
		sendInstr(rWord(7'h00, 5'd0, 5'd11, 3'd0, 5'd12), pcNext);
		sendInstr({20'($urandom), 5'd13, 7'b1101111}, pcNext);
		sendInstr(rWord(7'h00, 5'd0, 5'd13, 3'd0, 5'd14), pcNext);
		stallCycles <= 0;
		@(posedge clk);
		// long-held ack backs up the whole slice
		stallCycles <= 40;
		for (i = 0; i < 10; i++) begin
			sendRandomAlu();
		end
		stallCycles <= 0;
		count = 0;
		while ((expected.size() != 0) || (respState != RESP_IDLE)) begin
			count++;
			if (count > 2000) begin
				abortRun("results were still missing when the run ended");
			end
			@(posedge clk);
		end
		if (DUT.protoChecks.failCount != 0) begin
			abortRun("a protocol assertion on the external ports failed");
		end else begin
			$display("Everything OK");
			$finish;
		end
	end
endmodule

//--- dv/rvExecAssertions.sv
//********************
// protocol checks on the external four-phase ports
// failures are counted in failCount as well as reported
//********************
`timescale 1ns/1ps

module rvExecAssertions (
	input logic clk,
	input logic reset,
	input logic inRequest,
	input logic inAck,
	input logic outRequest,
	input logic outAck,
	input logic [4:0] outRd,
	input logic [31:0] outResult,
	input logic outIllegal
);
	// number of failed protocol checks
	int failCount;

	initial begin
		failCount = 0;
	end

	// both handshake outputs come out of reset low
	resetLow: assert property (@(posedge clk) reset |=> (!inAck && !outRequest))
		else begin
			failCount++;
			$error("inAck or outRequest high after reset");
		end

	// ack only answers a request
	ackNeedsRequest: assert property (@(posedge clk) disable iff (reset)
		$rose(inAck) |-> inRequest)
		else begin
			failCount++;
			$error("inAck rose without inRequest");
		end

	// ack falls once the request is gone
	ackFalls: assert property (@(posedge clk) disable iff (reset)
		(inAck && !inRequest) |=> !inAck)
		else begin
			failCount++;
			$error("inAck stayed high after inRequest fell");
		end

	// returned op held until acknowledged
	outStable: assert property (@(posedge clk) disable iff (reset)
		(outRequest && !outAck) |=>
		($stable(outRd) && $stable(outResult) && $stable(outIllegal)))
		else begin
			failCount++;
			$error("result port changed while outRequest waited for outAck");
		end

	// no new request until the old ack is gone
	reqWaits: assert property (@(posedge clk) disable iff (reset)
		(outAck && !outRequest) |=> !outRequest)
		else begin
			failCount++;
			$error("outRequest rose while outAck was still high");
		end
endmodule

bind rvExecTop rvExecAssertions protoChecks (.*);

//--- hdl/rvExecTop.sv
//********************
// RV32I integer slice, four-phase ports on both sides
// regCount of 16 gives an RV32E register file
//********************
`timescale 1ns/1ps

module rvExecTop #(
	parameter int regCount = 32
) (
	input logic clk,
	input logic reset,
	input logic inRequest,
	input logic [31:0] inInstr,
	input logic [31:0] inPc,
	output logic inAck,
	output logic outRequest,
	input logic outAck,
	output logic [4:0] outRd,
	output logic [31:0] outResult,
	output logic outIllegal
);
	// stage to stage links
	stageLink intakeLink();
	stageLink operandLink();
	stageLink executeLink();

	// write-back port
	logic wbEnable;
	logic [4:0] wbRd;
	logic [31:0] wbData;
	// bypass from the op in execute
	logic exValid;
	logic [4:0] exRd;
	logic [31:0] exResult;

	instrIntake uIntake (
		.clk(clk),
		.reset(reset),
		.inRequest(inRequest),
		.inInstr(inInstr),
		.inPc(inPc),
		.inAck(inAck),
		.toOperand(intakeLink.sender)
	);

	operandStage #(.regCount(regCount)) uOperand (
		.clk(clk),
		.reset(reset),
		.fromIntake(intakeLink.receiver),
		.toExecute(operandLink.sender),
		.wbEnable(wbEnable),
		.wbRd(wbRd),
		.wbData(wbData),
		.exValid(exValid),
		.exRd(exRd),
		.exResult(exResult)
	);

	executeStage uExecute (
		.clk(clk),
		.reset(reset),
		.fromOperand(operandLink.receiver),
		.toSender(executeLink.sender),
		.wbEnable(wbEnable),
		.wbRd(wbRd),
		.wbData(wbData),
		.exValid(exValid),
		.exRd(exRd),
		.exResult(exResult)
	);

	resultSender uSender (
		.clk(clk),
		.reset(reset),
		.fromExecute(executeLink.receiver),
		.outRequest(outRequest),
		.outAck(outAck),
		.outRd(outRd),
		.outResult(outResult),
		.outIllegal(outIllegal)
	);
endmodule

//--- hdl/resultSender.sv
//********************
// four-phase sender, one op at a time
// next op taken only after ack is seen low
//********************
`timescale 1ns/1ps

module resultSender import rvExecPkg::*; (
	input logic clk,
	input logic reset,
	stageLink.receiver fromExecute,
	output logic outRequest,
	input logic outAck,
	output logic [4:0] outRd,
	output logic [xLen-1:0] outResult,
	output logic outIllegal
);
	logic busy;
	logic take;
	logic [4:0] heldRd;
	logic [xLen-1:0] heldResult;
	logic heldIllegal;

	// busy covers the whole req/ack cycle
	assign fromExecute.ready = !busy;
	assign take = fromExecute.valid && !busy;

	always_ff @(posedge clk) begin
		if (reset) begin
			busy <= 1'b0;
			outRequest <= 1'b0;
		end else if (take) begin
			busy <= 1'b1;
			outRequest <= 1'b1;
		end else if (outRequest && outAck) begin
			// ack seen, drop req
			outRequest <= 1'b0;
		end else if (busy && !outRequest && !outAck) begin
			// ack back low, handshake done
			busy <= 1'b0;
		end
	end

	// reported op, stable while req is high
	always_ff @(posedge clk) begin
		if (take) begin
			heldRd <= fromExecute.op.rd;
			heldResult <= fromExecute.op.result;
			heldIllegal <= fromExecute.op.kind == KIND_ILLEGAL;
		end
	end

	assign outRd = heldRd;
	assign outResult = heldResult;
	assign outIllegal = heldIllegal;
endmodule

//--- hdl/executeStage.sv
//********************
// one op held in execute, result offered a cycle after accept
// write-back happens when the sender takes the op
//********************
`timescale 1ns/1ps

module executeStage import rvExecPkg::*; (
	input logic clk,
	input logic reset,
	stageLink.receiver fromOperand,
	stageLink.sender toSender,
	output logic wbEnable,
	output logic [4:0] wbRd,
	output logic [xLen-1:0] wbData,
	output logic exValid,
	output logic [4:0] exRd,
	output logic [xLen-1:0] exResult
);
	`include "aluCompute.svh"

	logic held;
	stageOpT exOp;
	logic [xLen-1:0] aluOut;
	logic [xLen-1:0] result;
	logic writes;

	// operands were placed in result and imm by the operand stage
	assign aluOut = aluCompute(exOp.aluOp, exOp.result, exOp.imm);

	// result per kind, illegal ops give zero
	always_comb begin
		case (exOp.kind)
			KIND_ALU:   result = aluOut;
			KIND_LUI:   result = exOp.imm;
			KIND_AUIPC: result = exOp.pc + exOp.imm;
			default:    result = '0;
		endcase
	end

	assign fromOperand.ready = !held || toSender.ready;

	always_ff @(posedge clk) begin
		if (reset) begin
			held <= 1'b0;
		end else if (fromOperand.ready) begin
			held <= fromOperand.valid;
		end
	end

	always_ff @(posedge clk) begin
		if (fromOperand.valid && fromOperand.ready) begin
			exOp <= fromOperand.op;
		end
	end

	always_comb begin
		toSender.op = exOp;
		toSender.op.result = result;
	end
	assign toSender.valid = held;

	// illegal ops never touch the file
	assign writes = exOp.kind != KIND_ILLEGAL;

	assign wbEnable = held && toSender.ready && writes && (exOp.rd != 5'd0);
	assign wbRd = exOp.rd;
	assign wbData = result;

	// bypass source for the operand stage
	assign exValid = held && writes;
	assign exRd = exOp.rd;
	assign exResult = result;
endmodule

//--- hdl/operandStage.sv
//********************
// register file with one write port, x0 always reads zero
// with regCount of 16 the upper register numbers alias
//********************
`timescale 1ns/1ps

module operandStage import rvExecPkg::*; #(
	parameter int regCount = 32
) (
	input logic clk,
	input logic reset,
	stageLink.receiver fromIntake,
	stageLink.sender toExecute,
	input logic wbEnable,
	input logic [4:0] wbRd,
	input logic [xLen-1:0] wbData,
	input logic exValid,
	input logic [4:0] exRd,
	input logic [xLen-1:0] exResult
);
	localparam int idxW = $clog2(regCount);

	logic [xLen-1:0] regFile [regCount];
	logic opValid;
	stageOpT opReg;
	logic [xLen-1:0] fileA;
	logic [xLen-1:0] fileB;
	logic [xLen-1:0] srcA;
	logic [xLen-1:0] srcB;
	logic bypassA;
	logic bypassB;

	// write on the edge the execute op leaves for the sender
	always_ff @(posedge clk) begin
		if (wbEnable) begin
			regFile[wbRd[idxW-1:0]] <= wbData;
		end
	end

	// file reads, register zero forced to zero
	assign fileA = (opReg.rs1 == 5'd0) ? '0 : regFile[opReg.rs1[idxW-1:0]];
	assign fileB = (opReg.rs2 == 5'd0) ? '0 : regFile[opReg.rs2[idxW-1:0]];

	// the op in execute is not written back yet, forward its result
	assign bypassA = exValid && (exRd != 5'd0) && (exRd == opReg.rs1);
	assign bypassB = exValid && (exRd != 5'd0) && (exRd == opReg.rs2);
	assign srcA = bypassA ? exResult : fileA;
	assign srcB = bypassB ? exResult : fileB;

	// take a new op when empty or when the held one moves on
	assign fromIntake.ready = !opValid || toExecute.ready;

	always_ff @(posedge clk) begin
		if (reset) begin
			opValid <= 1'b0;
		end else if (fromIntake.ready) begin
			opValid <= fromIntake.valid;
		end
	end

	// payload, no reset
	always_ff @(posedge clk) begin
		if (fromIntake.valid && fromIntake.ready) begin
			opReg <= fromIntake.op;
		end
	end

	// fold operands into the record
	// rs1 value rides in result, rs2 value replaces imm for R-type
	always_comb begin
		toExecute.op = opReg;
		toExecute.op.result = srcA;
		if (!opReg.useImm) begin
			toExecute.op.imm = srcB;
		end
	end

	assign toExecute.valid = opValid;
endmodule

//--- hdl/instrIntake.sv
//********************
// four-phase receiver, one op slot
// ack is withheld while the slot cannot take a new op
//********************
`timescale 1ns/1ps

module instrIntake import rvExecPkg::*; (
	input logic clk,
	input logic reset,
	input logic inRequest,
	input instrWordT inInstr,
	input logic [31:0] inPc,
	output logic inAck,
	stageLink.sender toOperand
);
	logic slotValid;
	stageOpT slotOp;
	stageOpT decoded;
	logic slotFree;
	logic capture;
	logic opAlt;
	logic immAlt;

	// slot is free when empty or being taken this edge
	assign slotFree = !slotValid || toOperand.ready;
	// new request only while ack is still low
	assign capture = inRequest && !inAck && slotFree;

	// funct7 bit 5 selects SUB and SRA, ignored elsewhere
	assign opAlt = inInstr.r.funct7[5] &&
		((inInstr.r.funct3 == 3'b000) || (inInstr.r.funct3 == 3'b101));
	// immediate bit 10 marks SRAI, there is no SUBI
	assign immAlt = inInstr.i.imm[10] && (inInstr.i.funct3 == 3'b101);

	// decode, defaults describe an illegal op
	always_comb begin
		decoded = '0;
		decoded.rd = inInstr.r.rd;
		decoded.rs1 = inInstr.r.rs1;
		decoded.rs2 = inInstr.r.rs2;
		decoded.pc = inPc;
		// sign-extended I-type immediate
		decoded.imm = {{(xLen-12){inInstr.i.imm[11]}}, inInstr.i.imm};
		decoded.useImm = 1'b1;
		decoded.aluOp = ALU_ADD;
		decoded.kind = KIND_ILLEGAL;
		case (inInstr.r.opcode)
			OP: begin
				decoded.kind = KIND_ALU;
				decoded.useImm = 1'b0;
				decoded.aluOp = aluOpT'({opAlt, inInstr.r.funct3});
			end
			OP_IMM: begin
				decoded.kind = KIND_ALU;
				decoded.aluOp = aluOpT'({immAlt, inInstr.i.funct3});
			end
			LUI: begin
				decoded.kind = KIND_LUI;
				decoded.imm = {inInstr.word[31:12], 12'b0};
			end
			AUIPC: begin
				decoded.kind = KIND_AUIPC;
				decoded.imm = {inInstr.word[31:12], 12'b0};
			end
			default: begin
				decoded.kind = KIND_ILLEGAL;
			end
		endcase
	end

	// four-phase state and slot occupancy
	always_ff @(posedge clk) begin
		if (reset) begin
			inAck <= 1'b0;
			slotValid <= 1'b0;
		end else begin
			// ack rises after capture, falls once req is seen low
			if (capture) begin
				inAck <= 1'b1;
			end else if (!inRequest) begin
				inAck <= 1'b0;
			end
			if (capture) begin
				slotValid <= 1'b1;
			end else if (toOperand.ready) begin
				slotValid <= 1'b0;
			end
		end
	end

	// payload, no reset
	always_ff @(posedge clk) begin
		if (capture) begin
			slotOp <= decoded;
		end
	end

	assign toOperand.valid = slotValid;
	assign toOperand.op = slotOp;
endmodule

//--- hdl/stageLink.sv
//********************
// valid/ready link between stages
// valid and op hold steady until ready is seen
//********************
`timescale 1ns/1ps

interface stageLink import rvExecPkg::*; ();
	// sender has an op on offer
	logic valid;
	// receiver can take it this edge
	logic ready;
	// the op itself
	stageOpT op;

	// driving side
	modport sender (
		output valid,
		output op,
		input  ready
	);

	// taking side
	modport receiver (
		input  valid,
		input  op,
		output ready
	);
endinterface

//--- hdl/rvExecPkg.sv
//********************
// RV32I integer subset only, no loads, stores, branches or jumps
// between operand and execute the result field carries the rs1 value
//********************
package rvExecPkg;
	// data and register width
	localparam int xLen = 32;

	// major opcodes the slice accepts
	typedef enum logic [6:0] {
		OP     = 7'b0110011,
		OP_IMM = 7'b0010011,
		LUI    = 7'b0110111,
		AUIPC  = 7'b0010111
	} opcodeT;

	// encoded as {funct7[5], funct3}
	typedef enum logic [3:0] {
		ALU_ADD  = 4'b0000,
		ALU_SLL  = 4'b0001,
		ALU_SLT  = 4'b0010,
		ALU_SLTU = 4'b0011,
		ALU_XOR  = 4'b0100,
		ALU_SRL  = 4'b0101,
		ALU_OR   = 4'b0110,
		ALU_AND  = 4'b0111,
		ALU_SUB  = 4'b1000,
		ALU_SRA  = 4'b1101
	} aluOpT;

	// op kind codes
	localparam logic [1:0] KIND_ALU     = 2'd0;
	localparam logic [1:0] KIND_LUI     = 2'd1;
	localparam logic [1:0] KIND_AUIPC   = 2'd2;
	localparam logic [1:0] KIND_ILLEGAL = 2'd3;

	// R-type field view
	typedef struct packed {
		logic [6:0] funct7;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] rd;
		logic [6:0] opcode;
	} rTypeT;

	// I-type field view
	typedef struct packed {
		logic [11:0] imm;
		logic [4:0]  rs1;
		logic [2:0]  funct3;
		logic [4:0]  rd;
		logic [6:0]  opcode;
	} iTypeT;

	// one instruction word, decoded both ways by the intake
	typedef union packed {
		logic [31:0] word;
		rTypeT       r;
		iTypeT       i;
	} instrWordT;

	// op record passed between stages
	// imm holds the second ALU operand once the operand stage has run
	typedef struct packed {
		logic [4:0]      rd;
		logic [4:0]      rs1;
		logic [4:0]      rs2;
		logic            useImm;
		logic [xLen-1:0] imm;
		logic [xLen-1:0] pc;
		aluOpT           aluOp;
		logic [1:0]      kind;
		logic [xLen-1:0] result;
	} stageOpT;
endpackage

//--- include/aluCompute.svh
//********************
// needs aluOpT and xLen from rvExecPkg in scope
// shifts use only the low five bits of b
//********************
`ifndef ALU_COMPUTE_SVH
`define ALU_COMPUTE_SVH

// all ten ALU operations of the integer subset
function automatic logic [xLen-1:0] aluCompute(
	input aluOpT aluOp,
	input logic [xLen-1:0] a,
	input logic [xLen-1:0] b
);
	logic [4:0] shamt;
	logic [xLen-1:0] y;
	shamt = b[4:0];
	case (aluOp)
		ALU_ADD:  y = a + b;
		ALU_SUB:  y = a - b;
		ALU_SLL:  y = a << shamt;
		// set-less-than gives 0 or 1 in bit zero
		ALU_SLT:  y = {{(xLen-1){1'b0}}, ($signed(a) < $signed(b))};
		ALU_SLTU: y = {{(xLen-1){1'b0}}, (a < b)};
		ALU_XOR:  y = a ^ b;
		ALU_SRL:  y = a >> shamt;
		// arithmetic shift keeps the sign bit
		ALU_SRA:  y = $signed(a) >>> shamt;
		ALU_OR:   y = a | b;
		ALU_AND:  y = a & b;
		default:  y = '0;
	endcase
	return y;
endfunction

`endif
